// File: tb.f
verilog/mdu_pkg.sv
verilog/mdu_exec_if.sv
verilog/mdu_multiplier.sv
verilog/mdu_divider.sv
verilog/mdu_ctrl.sv
verilog/mdu_top.sv
bench/mdu_top_chk.sv
bench/tb_mdu_top.sv

// File: run.sh
#!/bin/sh
# build and run the multiply/divide testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_mdu_top \
    -Mdir obj_dir -o vsim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/vsim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: bench/tb_mdu_top.sv
`timescale 1ns/1ps
/* testbench for the multiply/divide block: clock, reset, LFSR operands,
   test sequence, timeout and summary */
module tb_mdu_top;
    import mdu_pkg::*;

    localparam int XLEN     = MDU_XLEN;
    localparam int N_RAND   = 8;   // random operand pairs per op
    localparam int N_OPS    = 4 * (16 + N_RAND) + 4 * (N_RAND + 2) + 4 * 3 + 2;
    localparam int DONE_MAX = XLEN + 4;  // divide worst case with margin
    localparam int LIMIT    = 14 + N_OPS * (DONE_MAX + 4) + 100;
    localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};

    logic            clk_i = 1'b0;
    logic            rst;
    logic            valid_i;
    mdu_op_e         funct3_i;
    logic [XLEN-1:0] src1_i;
    logic [XLEN-1:0] src2_i;
    logic            busy_o;
    logic            done_o;
    logic [XLEN-1:0] rslt_o;

    logic [31:0]     lfsr_q = 32'h7d6b_d8b6;
    int              ops_done = 0;
    int              missed = 0;
    int              cycles = 0;

    always #2 clk_i = ~clk_i;

    mdu_top #(.XLEN(XLEN)) mdu_top_i (.*);

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [XLEN-1:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[XLEN-2:0], lfsr_q[0]};
        end
    endtask

    task automatic wait_done(input mdu_op_e op);
        int wait_cyc;
        wait_cyc = 0;
        while (!done_o && wait_cyc < DONE_MAX) begin
            @(posedge clk_i);
            #1;
            wait_cyc++;
        end
        if (done_o) begin
            ops_done++;
        end else begin
            missed++;
            $display("no done_o within %0d cycles for %s at %0t", DONE_MAX, op.name(), $time);
        end
    endtask

    task automatic run_op(input mdu_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
        valid_i  = 1'b1;
        funct3_i = op;
        src1_i   = a;
        src2_i   = b;
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        wait_done(op);
    endtask

    // divide, with a stray multiply request held while it runs
    task automatic ignore_while_busy(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        run_op_start(OP_DIV, a, b | XLEN'(1));
        funct3_i = OP_MUL;
        src1_i   = ~a;
        repeat (3) @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        wait_done(OP_DIV);
    endtask

    task automatic run_op_start(input mdu_op_e op, input logic [XLEN-1:0] a,
                                input logic [XLEN-1:0] b);
        valid_i  = 1'b1;
        funct3_i = op;
        src1_i   = a;
        src2_i   = b;
        @(posedge clk_i);
        #1;
    endtask

    task automatic report_test(input string name, input int first);
        $display("test %s: %0d operations completed", name, ops_done - first);
    endtask

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout after %0d cycles, done_o never arrived", LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [XLEN-1:0] corner [4];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              first;
        int              fails;
        corner   = '{'0, XLEN'(1), '1, MIN_VAL};
        rst      = 1'b1;
        valid_i  = 1'b0;
        funct3_i = OP_MUL;
        src1_i   = '0;
        src2_i   = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rst = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        report_test("reset", ops_done);

        first = ops_done;
        for (int o = 0; o < 4; o++) begin
            for (int i = 0; i < 16; i++) begin
                run_op(mdu_op_e'(o), corner[i / 4], corner[i % 4]);
            end
            for (int r = 0; r < N_RAND; r++) begin
                take_bits(XLEN, a);
                take_bits(XLEN, b);
                run_op(mdu_op_e'(o), a, b);
            end
        end
        report_test("multiply", first);

        first = ops_done;
        for (int o = 4; o < 8; o++) begin
            for (int r = 0; r < N_RAND; r++) begin
                take_bits(XLEN, a);
                take_bits((r % 2 == 0) ? XLEN : 8, b);  // small divisors too
                if (r % 4 == 3) b = -b;
                if (b == '0) b = XLEN'(3);
                run_op(mdu_op_e'(o), a, b);
            end
            run_op(mdu_op_e'(o), MIN_VAL, '1);
            run_op(mdu_op_e'(o), MIN_VAL, XLEN'(1));
        end
        report_test("divide", first);

        first = ops_done;
        for (int o = 4; o < 8; o++) begin
            take_bits(XLEN, a);
            run_op(mdu_op_e'(o), a, '0);
            run_op(mdu_op_e'(o), MIN_VAL, '0);
            run_op(mdu_op_e'(o), '0, '0);
        end
        report_test("divide by zero", first);

        first = ops_done;
        for (int r = 0; r < 2; r++) begin
            take_bits(XLEN, a);
            take_bits(XLEN, b);
            ignore_while_busy(a, b);
        end
        report_test("busy", first);

        repeat (4) @(posedge clk_i);
        #1;
        fails = mdu_top_i.chk_i.fail_cnt + missed;
        $display("summary: %0d operations, %0d assertion failures, %0d missing done_o",
                 ops_done, mdu_top_i.chk_i.fail_cnt, missed);
        if (fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: bench/mdu_top_chk.sv
`timescale 1ns/1ps
/* bound checker for the multiply/divide block:
   reference model plus result, latency, busy and reset assertions */
module mdu_top_chk #(
    parameter int XLEN = 32
) (
    input logic             clk_i,
    input logic             rst,
    input logic             valid_i,
    input mdu_pkg::mdu_op_e funct3_i,
    input logic [XLEN-1:0]  src1_i,
    input logic [XLEN-1:0]  src2_i,
    input logic             busy_o,
    input logic             done_o,
    input logic [XLEN-1:0]  rslt_o
);
    import mdu_pkg::*;

    localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};

    logic            accept;
    logic            outstanding;  // accepted, done_o still to come
    logic [XLEN-1:0] exp_rslt;
    int unsigned     fail_cnt = 0;

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic [XLEN-1:0] ref_result(input mdu_op_e op,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] ea;
        logic [2*XLEN-1:0] eb;
        logic [2*XLEN-1:0] prod;
        logic              ovf;
        ea   = {{XLEN{(op == OP_MULH || op == OP_MULHSU) && a[XLEN-1]}}, a};
        eb   = {{XLEN{(op == OP_MULH) && b[XLEN-1]}}, b};
        prod = ea * eb;  // low 2*XLEN bits are exact
        ovf  = (a == MIN_VAL) && (b == '1);
        if (op == OP_MUL) return prod[XLEN-1:0];
        if (!op[2]) return prod[2*XLEN-1:XLEN];
        if (b == '0) return (op == OP_DIV || op == OP_DIVU) ? '1 : a;
        case (op)
            OP_DIV:  return ovf ? a : $unsigned($signed(a) / $signed(b));
            OP_DIVU: return a / b;
            OP_REM:  return ovf ? '0 : $unsigned($signed(a) % $signed(b));
            default: return a % b;
        endcase
    endfunction

    task automatic flag_failure(input string msg);
        $error("%s", msg);
        fail_cnt++;
    endtask

    assign accept = valid_i && !busy_o;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            outstanding <= 1'b0;
            exp_rslt    <= '0;
        end else if (accept) begin
            outstanding <= 1'b1;
            exp_rslt    <= ref_result(funct3_i, src1_i, src2_i);
        end else if (done_o) begin
            outstanding <= 1'b0;
        end
    end

    // ----------------------------------------
    // assertions
    // ----------------------------------------
    a_result: assert property (@(posedge clk_i) disable iff (rst) done_o |-> rslt_o == exp_rslt)
        else flag_failure($sformatf("** Error t=%0t: rslt_o %h, expected %h",
                                    $time, $sampled(rslt_o), $sampled(exp_rslt)));
    a_mul_lat: assert property (@(posedge clk_i) disable iff (rst)
        accept && !funct3_i[2] |=> !done_o ##1 !done_o ##1 done_o)
        else flag_failure("multiply did not finish exactly 3 cycles after acceptance");
    a_pulse: assert property (@(posedge clk_i) disable iff (rst) done_o |=> !done_o)
        else flag_failure("done_o stayed high for more than one cycle");
    a_busy_set: assert property (@(posedge clk_i) disable iff (rst) accept |=> busy_o)
        else flag_failure("busy_o did not rise after an accepted operation");
    a_busy_hold: assert property (@(posedge clk_i) disable iff (rst)
        busy_o |=> busy_o || done_o)
        else flag_failure("busy_o dropped before done_o");
    a_busy_drop: assert property (@(posedge clk_i) disable iff (rst) done_o |-> !busy_o)
        else flag_failure("busy_o still high in the done_o cycle");
    a_no_extra: assert property (@(posedge clk_i) disable iff (rst) done_o |-> outstanding)
        else flag_failure("done_o without an accepted operation");
    a_reset: assert property (@(posedge clk_i)
        $fell(rst) |-> !busy_o && !done_o && rslt_o == '0)
        else flag_failure("outputs not cleared by reset");

endmodule

bind mdu_top mdu_top_chk #(.XLEN(XLEN)) chk_i (
    .clk_i   (clk_i),
    .rst     (rst),
    .valid_i (valid_i),
    .funct3_i(funct3_i),
    .src1_i  (src1_i),
    .src2_i  (src2_i),
    .busy_o  (busy_o),
    .done_o  (done_o),
    .rslt_o  (rslt_o)
);

// File: verilog/mdu_top.sv
`timescale 1ns/1ps
/* M-extension execution block: control block, multiplier and divider */
module mdu_top #(
    parameter int XLEN = mdu_pkg::MDU_XLEN
) (
    input  logic             clk_i,
    input  logic             rst,
    input  logic             valid_i,
    input  mdu_pkg::mdu_op_e funct3_i,
    input  logic [XLEN-1:0]  src1_i,
    input  logic [XLEN-1:0]  src2_i,
    output logic             busy_o,
    output logic             done_o,
    output logic [XLEN-1:0]  rslt_o
);
    import mdu_pkg::*;

    mdu_exec_if #(.XLEN(XLEN), .ctrl_t(mul_ctrl_t)) mul_if ();  // to multiplier
    mdu_exec_if #(.XLEN(XLEN), .ctrl_t(div_ctrl_t)) div_if ();  // to divider

    mdu_ctrl #(
        .XLEN(XLEN)
    ) mdu_ctrl_i (
        .clk_i   (clk_i),
        .rst     (rst),
        .valid_i (valid_i),
        .funct3_i(funct3_i),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .mul_port(mul_if.ctrl),
        .div_port(div_if.ctrl),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .rslt_o  (rslt_o)
    );

    mdu_multiplier #(
        .XLEN(XLEN)
    ) mdu_multiplier_i (
        .clk_i(clk_i),
        .rst  (rst),
        .port (mul_if.unit)
    );

    mdu_divider #(
        .XLEN(XLEN)
    ) mdu_divider_i (
        .clk_i(clk_i),
        .rst  (rst),
        .port (div_if.unit)
    );

endmodule

// File: verilog/mdu_ctrl.sv
`timescale 1ns/1ps
/* funct3 decode, issue to multiplier or divider, busy tracking,
   registered result and done pulse */
module mdu_ctrl #(
    parameter int XLEN = 32
) (
    input  logic             clk_i,
    input  logic             rst,
    input  logic             valid_i,
    input  mdu_pkg::mdu_op_e funct3_i,
    input  logic [XLEN-1:0]  src1_i,
    input  logic [XLEN-1:0]  src2_i,
    mdu_exec_if.ctrl         mul_port,
    mdu_exec_if.ctrl         div_port,
    output logic             busy_o,
    output logic             done_o,
    output logic [XLEN-1:0]  rslt_o
);
    import mdu_pkg::*;

    mul_ctrl_t       mul_dec;
    div_ctrl_t       div_dec;
    logic            accept;     // operation taken this cycle
    logic            is_div;
    logic            unit_done;
    logic [XLEN-1:0] unit_rslt;

    // ----------------------------------------
    // funct3 decode
    // ----------------------------------------
    always_comb begin
        mul_dec.src1_signed = funct3_i inside {OP_MULH, OP_MULHSU};
        mul_dec.src2_signed = (funct3_i == OP_MULH);
        mul_dec.high        = (funct3_i != OP_MUL);
        div_dec.is_signed   = funct3_i inside {OP_DIV, OP_REM};
        div_dec.is_rem      = funct3_i inside {OP_REM, OP_REMU};
    end

    assign is_div = funct3_i[2];  // upper four codes divide
    assign accept = valid_i & ~busy_o;

    // ----------------------------------------
    // issue
    // ----------------------------------------
    assign mul_port.start   = accept & ~is_div;
    assign mul_port.src1    = src1_i;
    assign mul_port.src2    = src2_i;
    assign mul_port.op_ctrl = mul_dec;

    assign div_port.start   = accept & is_div;
    assign div_port.src1    = src1_i;
    assign div_port.src2    = src2_i;
    assign div_port.op_ctrl = div_dec;

    // pick the unit that reports completion
    assign unit_done = mul_port.rslt_valid | div_port.rslt_valid;
    assign unit_rslt = div_port.rslt_valid ? div_port.rslt : mul_port.rslt;

    // ----------------------------------------
    // busy, done and result registers
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            rslt_o <= '0;
        end else begin
            done_o <= unit_done;
            if (unit_done) begin
                busy_o <= 1'b0;       // next op can be taken with done
                rslt_o <= unit_rslt;
            end else if (accept) begin
                busy_o <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/mdu_divider.sv
`timescale 1ns/1ps
/* iterative restoring divider for DIV, DIVU, REM and REMU,
   with sign handling and the divide-by-zero shortcut */
module mdu_divider #(
    parameter int XLEN = 32
) (
    input  logic     clk_i,
    input  logic     rst,
    mdu_exec_if.unit port
);
    import mdu_pkg::*;

    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_CHECK,
        DIV_EXEC,
        DIV_RET
    } div_state_e;

    div_state_e       state;
    div_ctrl_t        ctl;
    logic [CNT_W-1:0] cntr;          // remaining shift-subtract steps
    logic             is_rem;
    logic             dividend_neg;
    logic             divisor_neg;
    logic             quo_neg;       // negate quotient on return
    logic             rem_neg;       // negate remainder on return
    logic [XLEN-1:0]  remainder;
    logic [XLEN-1:0]  quotient;
    logic [XLEN-1:0]  divisor;
    logic [XLEN-1:0]  abs_dividend;
    logic [XLEN-1:0]  abs_divisor;
    logic [XLEN:0]    shifted;       // partial remainder shifted left
    logic [XLEN+1:0]  diff;
    logic             q_bit;
    logic             div_zero;

    assign ctl          = port.op_ctrl;
    assign abs_dividend = dividend_neg ? -remainder : remainder;
    assign abs_divisor  = divisor_neg ? -divisor : divisor;
    assign div_zero     = (divisor == '0);
    assign shifted      = {remainder, quotient[XLEN-1]};
    assign diff         = {1'b0, shifted} - {2'b00, divisor};
    assign q_bit        = ~diff[XLEN+1];  // no borrow, subtract fits

    // ----------------------------------------
    // FSM and step counter
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst) begin
            state <= DIV_IDLE;
            cntr  <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (port.start) begin
                        state <= DIV_CHECK;
                    end
                end
                DIV_CHECK: begin
                    state <= div_zero ? DIV_RET : DIV_EXEC;
                    cntr  <= CNT_W'(XLEN - 1);
                end
                DIV_EXEC: begin
                    cntr <= cntr - 1'b1;
                    if (cntr == '0) begin
                        state <= DIV_RET;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        case (state)
            DIV_IDLE: begin
                if (port.start) begin
                    is_rem       <= ctl.is_rem;
                    dividend_neg <= ctl.is_signed & port.src1[XLEN-1];
                    divisor_neg  <= ctl.is_signed & port.src2[XLEN-1];
                    quo_neg      <= ctl.is_signed & (port.src1[XLEN-1] ^ port.src2[XLEN-1]);
                    rem_neg      <= ctl.is_signed & port.src1[XLEN-1];
                    remainder    <= port.src1;  // dividend parked here
                    divisor      <= port.src2;
                end
            end
            DIV_CHECK: begin
                if (div_zero) begin
                    // all ones quotient, remainder keeps the dividend
                    quotient <= '1;
                    quo_neg  <= 1'b0;
                    rem_neg  <= 1'b0;
                end else begin
                    divisor   <= abs_divisor;
                    remainder <= '0;
                    quotient  <= abs_dividend;  // shifted out msb first
                end
            end
            DIV_EXEC: begin
                remainder <= q_bit ? diff[XLEN-1:0] : shifted[XLEN-1:0];
                quotient  <= {quotient[XLEN-2:0], q_bit};
            end
            default: ;
        endcase
    end

    assign port.rslt_valid = (state == DIV_RET);
    assign port.rslt       = is_rem ? (rem_neg ? -remainder : remainder)
                                    : (quo_neg ? -quotient : quotient);

endmodule

// File: verilog/mdu_multiplier.sv
`timescale 1ns/1ps
/* two-cycle multiplier for MUL, MULH, MULHSU and MULHU */
module mdu_multiplier #(
    parameter int XLEN = 32
) (
    input  logic     clk_i,
    input  logic     rst,
    mdu_exec_if.unit port
);
    import mdu_pkg::*;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_EXEC,
        MUL_RET
    } mul_state_e;

    mul_state_e               state;
    mul_ctrl_t                ctl;
    logic signed [XLEN:0]     mcand;      // src1 with extension bit
    logic signed [XLEN:0]     mplier;     // src2 with extension bit
    logic signed [2*XLEN+1:0] prod_full;
    logic        [2*XLEN-1:0] product;
    logic                     is_high;

    assign ctl       = port.op_ctrl;
    // one signed multiply covers all four signedness mixes
    assign prod_full = mcand * mplier;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            state <= MUL_IDLE;
        end else begin
            case (state)
                MUL_IDLE: begin
                    if (port.start) begin
                        state <= MUL_EXEC;
                    end
                end
                MUL_EXEC: state <= MUL_RET;
                default:  state <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == MUL_IDLE && port.start) begin
            mcand   <= {ctl.src1_signed & port.src1[XLEN-1], port.src1};
            mplier  <= {ctl.src2_signed & port.src2[XLEN-1], port.src2};
            is_high <= ctl.high;
        end
        if (state == MUL_EXEC) begin
            product <= prod_full[2*XLEN-1:0];  // drop extension bits
        end
    end

    assign port.rslt_valid = (state == MUL_RET);
    assign port.rslt       = is_high ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

endmodule

// File: verilog/mdu_exec_if.sv
`timescale 1ns/1ps
/* link between the control block and one arithmetic unit,
   the control payload type is set per instance */
interface mdu_exec_if #(
    parameter int  XLEN   = 32,
    parameter type ctrl_t = logic
) ();

    logic            start;       // one-cycle issue strobe
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    ctrl_t           op_ctrl;     // unit specific control
    logic            rslt_valid;  // one-cycle completion pulse
    logic [XLEN-1:0] rslt;

    modport ctrl (
        output start,
        output src1,
        output src2,
        output op_ctrl,
        input  rslt_valid,
        input  rslt
    );

    modport unit (
        input  start,
        input  src1,
        input  src2,
        input  op_ctrl,
        output rslt_valid,
        output rslt
    );

endinterface

// File: verilog/mdu_pkg.sv
/* operation codes, unit control payloads and default width
   shared by the multiply/divide block */
package mdu_pkg;

    parameter int MDU_XLEN = 32;  // default operand width

    // ----------------------------------------
    // funct3 codes of the M extension
    // ----------------------------------------
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } mdu_op_e;

    // ----------------------------------------
    // unit control payloads
    // ----------------------------------------
    typedef struct packed {
        logic src1_signed;  // sign-extend src1
        logic src2_signed;  // sign-extend src2
        logic high;         // upper half of product
    } mul_ctrl_t;

    typedef struct packed {
        logic is_signed;    // DIV and REM
        logic is_rem;       // remainder, not quotient
    } div_ctrl_t;

endpackage
